// File: src/umi_consts.svh
//*****************************
// widths, opcodes and codes shared by the umi memory subsystem
// pull in with `include wherever a define is needed
//*****************************
`ifndef UMI_CONSTS_SVH
`define UMI_CONSTS_SVH

// bus widths
`define UMI_CW 32 // command word
`define UMI_AW 16 // word address
`define UMI_DW 32 // data word

`define UMI_MEM_DEPTH 64 // words in the endpoint array

// opcodes, requests carry an odd code
`define UMI_INVALID    5'd0
`define UMI_REQ_READ   5'd1
`define UMI_RESP_READ  5'd2
`define UMI_REQ_WRITE  5'd3
`define UMI_RESP_WRITE 5'd4
`define UMI_REQ_POSTED 5'd5
`define UMI_REQ_ATOMIC 5'd9

// atomic types, sit in the len/atype byte
`define UMI_ATOMIC_ADD  8'd0
`define UMI_ATOMIC_SWAP 8'd1
`define UMI_ATOMIC_AND  8'd2
`define UMI_ATOMIC_OR   8'd3
`define UMI_ATOMIC_XOR  8'd4

// response error codes in bits 26:25
`define UMI_ERR_OK     2'd0
`define UMI_ERR_DECODE 2'd2 // bad opcode, size or len
`define UMI_ERR_RANGE  2'd3 // address past the array

`define UMI_SIZE_WORD 3'd2 // 4 bytes, the only size served

`endif

// File: src/umi_pkg.sv
//*****************************
// types shared by the umi memory blocks
//*****************************
`include "umi_consts.svh"

package umi_pkg;

   // bus vectors
   typedef logic [`UMI_CW-1:0] umi_cmd_t;
   typedef logic [`UMI_AW-1:0] umi_addr_t;
   typedef logic [`UMI_DW-1:0] umi_data_t;

   // command fields
   typedef logic [4:0] umi_opcode_t; // bits 4:0
   typedef logic [7:0] umi_atype_t;  // bits 15:8 on atomics
   typedef logic [1:0] umi_err_t;    // bits 26:25 on responses
   typedef logic [4:0] umi_hostid_t; // bits 31:27

   // arbiter remembers which port it served last
   typedef enum logic {
      last_port0,
      last_port1
   } arb_state_t;

   // endpoint has a response on the bus or not
   typedef enum logic {
      idle,
      respond
   } ep_state_t;

endpackage

// File: src/umi_unpack.sv
//*****************************
// splits a umi command word into its control fields, no state
//*****************************
`include "umi_consts.svh"

module umi_unpack (
   input  umi_pkg::umi_cmd_t    packet_cmd,
   output umi_pkg::umi_opcode_t cmd_opcode,
   output logic [2:0]           cmd_size,
   output logic [7:0]           cmd_len,
   output umi_pkg::umi_atype_t  cmd_atype,
   output logic [3:0]           cmd_qos,
   output logic [1:0]           cmd_prot,
   output logic                 cmd_eom,
   output logic                 cmd_eof,
   output logic                 cmd_ex,
   output logic [1:0]           cmd_user,
   output logic [23:0]          cmd_user_extended,
   output umi_pkg::umi_err_t    cmd_err,
   output umi_pkg::umi_hostid_t cmd_hostid,
   output logic                 cmd_response,
   output logic                 cmd_atomic
);

   // even opcode that is not invalid means a response
   assign cmd_response = ~packet_cmd[0] & (packet_cmd[4:0] != `UMI_INVALID);
   assign cmd_atomic   = (packet_cmd[4:0] == `UMI_REQ_ATOMIC);

   assign cmd_opcode = packet_cmd[4:0];
   assign cmd_size   = packet_cmd[7:5];

   // on atomics byte 1 is the atype, so len reads as zero
   assign cmd_len   = {8{~cmd_atomic}} & packet_cmd[15:8];
   assign cmd_atype = packet_cmd[15:8];

   assign cmd_qos  = packet_cmd[19:16];
   assign cmd_prot = packet_cmd[21:20];
   assign cmd_eom  = packet_cmd[22]; // end of message
   assign cmd_eof  = packet_cmd[23]; // end of frame
   assign cmd_ex   = packet_cmd[24]; // exclusive

   // bits 26:25 are user bits on requests, err on responses
   assign cmd_user = packet_cmd[26:25];
   assign cmd_err  = {2{cmd_response}} & packet_cmd[26:25];

   assign cmd_hostid = packet_cmd[31:27];

   // upper 24 bits as one extended user field
   assign cmd_user_extended = packet_cmd[31:8];

endmodule

// File: src/umi_req_arbiter.sv
//*****************************
// two-port round-robin request arbiter, one held request per port
// busy stays high from capture until the request goes to the endpoint
//*****************************
module umi_req_arbiter (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req0_valid,
   input  umi_pkg::umi_cmd_t  req0_cmd,
   input  umi_pkg::umi_addr_t req0_addr,
   input  umi_pkg::umi_data_t req0_data,
   input  logic               req1_valid,
   input  umi_pkg::umi_cmd_t  req1_cmd,
   input  umi_pkg::umi_addr_t req1_addr,
   input  umi_pkg::umi_data_t req1_data,
   output logic               req0_busy,
   output logic               req1_busy,
   output logic               mem_valid,
   output umi_pkg::umi_cmd_t  mem_cmd,
   output umi_pkg::umi_addr_t mem_addr,
   output umi_pkg::umi_data_t mem_data
);

   // port inputs gathered by index
   logic [1:0]         in_valid;
   umi_pkg::umi_cmd_t  in_cmd  [2];
   umi_pkg::umi_addr_t in_addr [2];
   umi_pkg::umi_data_t in_data [2];

   // hold registers and pending flags
   logic [1:0]         pend_q;
   umi_pkg::umi_cmd_t  hold_cmd  [2];
   umi_pkg::umi_addr_t hold_addr [2];
   umi_pkg::umi_data_t hold_data [2];

   umi_pkg::arb_state_t last_q; // port served most recently
   logic [1:0]          accept;
   logic [1:0]          grant;
   logic                gsel; // 1 picks port 1

   assign in_valid   = {req1_valid, req0_valid};
   assign in_cmd[0]  = req0_cmd;
   assign in_cmd[1]  = req1_cmd;
   assign in_addr[0] = req0_addr;
   assign in_addr[1] = req1_addr;
   assign in_data[0] = req0_data;
   assign in_data[1] = req1_data;

   assign accept = in_valid & ~pend_q; // a strobe under busy is lost

   // port 0 wins when alone or when port 1 went last
   always_comb begin
      grant = 2'b00;
      if (pend_q[0] && (!pend_q[1] || last_q == umi_pkg::last_port1)) begin
         grant[0] = 1'b1;
      end else if (pend_q[1]) begin
         grant[1] = 1'b1;
      end
   end

   assign gsel = grant[1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pend_q    <= 2'b00;
         mem_valid <= 1'b0;
         last_q    <= umi_pkg::last_port1; // first tie goes to port 0
      end else begin
         pend_q    <= (pend_q & ~grant) | accept; // grant and accept never overlap
         mem_valid <= |grant;
         if (grant[0]) begin
            last_q <= umi_pkg::last_port0;
         end else if (grant[1]) begin
            last_q <= umi_pkg::last_port1;
         end
      end
   end

   // payload, captured on accept and forwarded on grant
   always_ff @(posedge clk) begin
      for (int p = 0; p < 2; p++) begin
         if (accept[p]) begin
            hold_cmd[p]  <= in_cmd[p];
            hold_addr[p] <= in_addr[p];
            hold_data[p] <= in_data[p];
         end
      end
      if (|grant) begin
         mem_cmd  <= hold_cmd[gsel];
         mem_addr <= hold_addr[gsel];
         mem_data <= hold_data[gsel];
      end
   end

   assign req0_busy = pend_q[0];
   assign req1_busy = pend_q[1];

endmodule

// File: src/umi_mem_endpoint.sv
//*****************************
// umi memory endpoint, checks and executes one request per cycle
// answers one cycle after mem_valid, posted writes stay silent
//*****************************
`include "umi_consts.svh"

module umi_mem_endpoint #(
   parameter int depth = `UMI_MEM_DEPTH
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               mem_valid,
   input  umi_pkg::umi_cmd_t  mem_cmd,
   input  umi_pkg::umi_addr_t mem_addr,
   input  umi_pkg::umi_data_t mem_data,
   output logic               resp_valid,
   output umi_pkg::umi_cmd_t  resp_cmd,
   output umi_pkg::umi_data_t resp_data
);

   localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

   umi_pkg::umi_data_t mem [depth]; // word array
   umi_pkg::ep_state_t state_q;

   // fields from the unpacker
   umi_pkg::umi_opcode_t opcode;
   logic [2:0]           size;
   logic [7:0]           len;
   umi_pkg::umi_atype_t  atype;
   logic [3:0]           qos;
   logic [1:0]           prot;
   umi_pkg::umi_hostid_t hostid;
   logic                 is_atomic;

   logic [idx_w-1:0]     idx;
   logic                 op_read;
   logic                 op_write;
   logic                 op_posted;
   logic                 op_known;
   umi_pkg::umi_err_t    err;
   umi_pkg::umi_data_t   old_data;
   umi_pkg::umi_data_t   new_data;
   logic                 wr_en;
   logic                 resp_due;
   umi_pkg::umi_opcode_t resp_opcode;

   umi_unpack unpack_i (
      .packet_cmd        (mem_cmd),
      .cmd_opcode        (opcode),
      .cmd_size          (size),
      .cmd_len           (len),
      .cmd_atype         (atype),
      .cmd_qos           (qos),
      .cmd_prot          (prot),
      .cmd_eom           (),
      .cmd_eof           (),
      .cmd_ex            (),
      .cmd_user          (),
      .cmd_user_extended (),
      .cmd_err           (),
      .cmd_hostid        (hostid),
      .cmd_response      (),
      .cmd_atomic        (is_atomic)
   );

   assign op_read   = (opcode == `UMI_REQ_READ);
   assign op_write  = (opcode == `UMI_REQ_WRITE);
   assign op_posted = (opcode == `UMI_REQ_POSTED);

   // unknown atype counts as a bad opcode
   assign op_known = op_read | op_write | op_posted |
                     (is_atomic & (atype <= `UMI_ATOMIC_XOR));

   // decode first, range second
   always_comb begin
      if (!op_known || size != `UMI_SIZE_WORD || len != 8'd0) begin
         err = `UMI_ERR_DECODE;
      end else if (mem_addr >= umi_pkg::umi_addr_t'(depth)) begin
         err = `UMI_ERR_RANGE;
      end else begin
         err = `UMI_ERR_OK;
      end
   end

   assign idx      = mem_addr[idx_w-1:0];
   assign old_data = mem[idx]; // value before this request

   // value left in memory by a write or atomic
   always_comb begin
      new_data = mem_data; // plain and posted writes
      if (is_atomic) begin
         case (atype)
            `UMI_ATOMIC_ADD:  new_data = old_data + mem_data;
            `UMI_ATOMIC_SWAP: new_data = mem_data;
            `UMI_ATOMIC_AND:  new_data = old_data & mem_data;
            `UMI_ATOMIC_OR:   new_data = old_data | mem_data;
            `UMI_ATOMIC_XOR:  new_data = old_data ^ mem_data;
            default:          new_data = old_data; // rejected by decode
         endcase
      end
   end

   // failed requests leave memory alone
   assign wr_en = mem_valid & (err == `UMI_ERR_OK) & (op_write | op_posted | is_atomic);

   // only a clean posted write goes unanswered
   assign resp_due = !(op_posted && err == `UMI_ERR_OK);

   // write kinds get RESP_WRITE, everything else incl. junk gets RESP_READ
   assign resp_opcode = (op_write | op_posted) ? `UMI_RESP_WRITE : `UMI_RESP_READ;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[idx] <= new_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= umi_pkg::idle;
      end else if (mem_valid && resp_due) begin
         state_q <= umi_pkg::respond;
      end else begin
         state_q <= umi_pkg::idle;
      end
   end

   // response word: hostid, err, ex, eof, eom, prot, qos, len, size, opcode
   always_ff @(posedge clk) begin
      if (mem_valid) begin
         resp_cmd <= {hostid, err, 1'b0, 1'b0, 1'b1, prot, qos, 8'h00, size, resp_opcode};
         // reads and atomics return the old word, writes and errors zero
         if (err == `UMI_ERR_OK && (op_read || is_atomic)) begin
            resp_data <= old_data;
         end else begin
            resp_data <= '0;
         end
      end
   end

   assign resp_valid = (state_q == umi_pkg::respond);

endmodule

// File: src/umi_mem_top.sv
//*****************************
// umi memory subsystem top, two request ports into one endpoint
//*****************************
`include "umi_consts.svh"

module umi_mem_top #(
   parameter int depth = `UMI_MEM_DEPTH
) (
   input  logic               clk,
   input  logic               rst_n,
   // port 0
   input  logic               req0_valid,
   input  umi_pkg::umi_cmd_t  req0_cmd,
   input  umi_pkg::umi_addr_t req0_addr,
   input  umi_pkg::umi_data_t req0_data,
   output logic               req0_busy,
   // port 1
   input  logic               req1_valid,
   input  umi_pkg::umi_cmd_t  req1_cmd,
   input  umi_pkg::umi_addr_t req1_addr,
   input  umi_pkg::umi_data_t req1_data,
   output logic               req1_busy,
   // shared response bus, hostid tells the ports apart
   output logic               resp_valid,
   output umi_pkg::umi_cmd_t  resp_cmd,
   output umi_pkg::umi_data_t resp_data
);

   // arbiter to endpoint
   logic               mem_valid;
   umi_pkg::umi_cmd_t  mem_cmd;
   umi_pkg::umi_addr_t mem_addr;
   umi_pkg::umi_data_t mem_data;

   umi_req_arbiter arb_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .req0_valid (req0_valid),
      .req0_cmd   (req0_cmd),
      .req0_addr  (req0_addr),
      .req0_data  (req0_data),
      .req1_valid (req1_valid),
      .req1_cmd   (req1_cmd),
      .req1_addr  (req1_addr),
      .req1_data  (req1_data),
      .req0_busy  (req0_busy),
      .req1_busy  (req1_busy),
      .mem_valid  (mem_valid),
      .mem_cmd    (mem_cmd),
      .mem_addr   (mem_addr),
      .mem_data   (mem_data)
   );

   umi_mem_endpoint #(
      .depth (depth)
   ) ep_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .mem_valid  (mem_valid),
      .mem_cmd    (mem_cmd),
      .mem_addr   (mem_addr),
      .mem_data   (mem_data),
      .resp_valid (resp_valid),
      .resp_cmd   (resp_cmd),
      .resp_data  (resp_data)
   );

endmodule

// File: verification/umi_mem_checker.sv
//*****************************
// testbench checker, predicts each umi response and compares it
// follows accepted strobes, grant order and a reference memory
//*****************************
`include "umi_consts.svh"

module umi_mem_checker #(
   parameter int depth = `UMI_MEM_DEPTH
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req0_valid,
   input  umi_pkg::umi_cmd_t  req0_cmd,
   input  umi_pkg::umi_addr_t req0_addr,
   input  umi_pkg::umi_data_t req0_data,
   input  logic               req0_busy,
   input  logic [10:0]        req0_exp, // test number, expected err, response due
   input  logic               req1_valid,
   input  umi_pkg::umi_cmd_t  req1_cmd,
   input  umi_pkg::umi_addr_t req1_addr,
   input  umi_pkg::umi_data_t req1_data,
   input  logic               req1_busy,
   input  logic [10:0]        req1_exp,
   input  logic               resp_valid,
   input  umi_pkg::umi_cmd_t  resp_cmd,
   input  umi_pkg::umi_data_t resp_data,
   output int                 done_count,
   output int                 fail_count
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int idx_w = $clog2(depth);

   // one outstanding request as the checker expects it back
   typedef struct packed {
      logic [7:0]         id;
      logic               port;
      logic [31:0]        due;  // cycle the response must show up
      logic               resp; // 0 for a clean posted write
      umi_pkg::umi_cmd_t  cmd;
      umi_pkg::umi_data_t data;
   } expect_t;

   umi_pkg::umi_data_t ref_mem [depth];
   expect_t            exp_q [$]; // in grant order
   logic [31:0]        cycle;
   logic               last_port; // port granted most recently
   int                 test_errs;

   // value an atomic leaves behind
   function automatic umi_pkg::umi_data_t combine(input umi_pkg::umi_atype_t atype,
                                                  input umi_pkg::umi_data_t  old,
                                                  input umi_pkg::umi_data_t  arg);
      case (atype)
         `UMI_ATOMIC_ADD:  return old + arg;
         `UMI_ATOMIC_SWAP: return arg;
         `UMI_ATOMIC_AND:  return old & arg;
         `UMI_ATOMIC_OR:   return old | arg;
         `UMI_ATOMIC_XOR:  return old ^ arg;
         default:          return old;
      endcase
   endfunction

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
         test_errs++;
      end
   endtask

   // model one request in the order it reaches the endpoint
   task automatic queue_request(input logic port, input umi_pkg::umi_cmd_t cmd,
                                input umi_pkg::umi_addr_t addr, input umi_pkg::umi_data_t data,
                                input logic [10:0] tag, input int lat);
      expect_t            e;
      umi_pkg::umi_data_t old;
      logic [4:0]         op;
      logic [4:0]         rop;
      logic [1:0]         err;
      op     = cmd[4:0];
      err    = tag[2:1];
      e.data = '0;
      if (err == `UMI_ERR_OK) begin // failed requests leave memory as it was
         old = ref_mem[addr[idx_w-1:0]];
         if (op == `UMI_REQ_READ || op == `UMI_REQ_ATOMIC) begin
            e.data = old; // atomics hand back the old word
         end
         if (op == `UMI_REQ_WRITE || op == `UMI_REQ_POSTED) begin
            ref_mem[addr[idx_w-1:0]] = data;
         end else if (op == `UMI_REQ_ATOMIC) begin
            ref_mem[addr[idx_w-1:0]] = combine(cmd[15:8], old, data);
         end
      end
      rop = (op == `UMI_REQ_WRITE || op == `UMI_REQ_POSTED) ? `UMI_RESP_WRITE : `UMI_RESP_READ;
      e.cmd  = {cmd[31:27], err, 3'b001, cmd[21:16], 8'h00, cmd[7:5], rop}; // eom set, len zero
      e.id   = tag[10:3];
      e.port = port;
      e.due  = cycle + 32'(lat);
      e.resp = tag[0];
      exp_q.push_back(e);
   endtask

   task automatic accept_request(input logic port, input int lat);
      if (port) begin
         queue_request(1'b1, req1_cmd, req1_addr, req1_data, req1_exp, lat);
      end else begin
         queue_request(1'b0, req0_cmd, req0_addr, req0_data, req0_exp, lat);
      end
      last_port = port;
   endtask

   always @(posedge clk) begin
      expect_t e;
      logic    acc0;
      logic    acc1;
      logic    first;
      if (!rst_n) begin
         exp_q.delete();
         cycle      = 0;
         last_port  = 1'b1; // so port 0 wins the first tie
         done_count = 0;
         fail_count = 0;
      end else begin
         cycle = cycle + 1;
         if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            e         = exp_q.pop_front();
            test_errs = 0;
            if (resp_valid && e.resp) begin
               compare("resp_cmd.opcode", 32'(e.cmd[4:0]), 32'(resp_cmd[4:0]));
               compare("resp_cmd.size", 32'(e.cmd[7:5]), 32'(resp_cmd[7:5]));
               compare("resp_cmd.len", 32'(e.cmd[15:8]), 32'(resp_cmd[15:8]));
               compare("resp_cmd.qos_prot", 32'(e.cmd[21:16]), 32'(resp_cmd[21:16]));
               compare("resp_cmd.eom", 32'(e.cmd[22]), 32'(resp_cmd[22]));
               compare("resp_cmd.err", 32'(e.cmd[26:25]), 32'(resp_cmd[26:25]));
               compare("resp_cmd.hostid", 32'(e.cmd[31:27]), 32'(resp_cmd[31:27]));
               compare("resp_data", e.data, resp_data);
            end else if (resp_valid) begin
               $display("ERROR at %0t: test %0d is a posted write but got a response", $time, e.id);
               test_errs++;
            end else if (e.resp) begin
               $display("ERROR at %0t: test %0d got no response when it was due", $time, e.id);
               test_errs++;
            end
            compare($sformatf("req%0d_busy", e.port), 32'd0, 32'(e.port ? req1_busy : req0_busy));
            fail_count = fail_count + test_errs;
            done_count = done_count + 1;
            if (test_errs == 0) begin
               $display("test %0d port %0d ok", e.id, e.port);
            end else begin
               $display("test %0d port %0d failed with %0d errors", e.id, e.port, test_errs);
            end
         end else if (resp_valid) begin
            $display("ERROR at %0t: response arrived with no request waiting for it", $time);
            fail_count = fail_count + 1;
         end
         // strobes under busy are dropped by the DUT too
         acc0 = req0_valid && !req0_busy;
         acc1 = req1_valid && !req1_busy;
         if (acc0 && acc1) begin
            first = ~last_port; // tie goes to the port not granted last
            accept_request(first, 3);
            accept_request(~first, 4); // waits one more cycle
         end else if (acc0) begin
            accept_request(1'b0, 3);
         end else if (acc1) begin
            accept_request(1'b1, 3);
         end
      end
   end

endmodule

// File: verification/umi_mem_tb.sv
//*****************************
// umi memory testbench, applies the request table to both ports
//*****************************
`include "umi_consts.svh"

module umi_mem_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // one request per row
   typedef struct packed {
      logic        port;
      logic [4:0]  opcode;
      logic [7:0]  atype;
      logic [2:0]  size;
      logic [7:0]  len;
      logic [15:0] addr;
      logic        rnd;  // random write data, zero otherwise
      logic [1:0]  err;  // expected error code
      logic        resp; // a response comes back
      logic        pair; // leaves in the same cycle as the next row
   } test_t;

   localparam logic [4:0] rd   = `UMI_REQ_READ;
   localparam logic [4:0] wr   = `UMI_REQ_WRITE;
   localparam logic [4:0] pw   = `UMI_REQ_POSTED;
   localparam logic [4:0] at   = `UMI_REQ_ATOMIC;
   localparam logic [2:0] word = `UMI_SIZE_WORD;
   localparam logic [1:0] e_ok  = `UMI_ERR_OK;
   localparam logic [1:0] e_dec = `UMI_ERR_DECODE;
   localparam logic [1:0] e_rng = `UMI_ERR_RANGE;

   logic               clk;
   logic               rst_n;
   logic               req0_valid;
   logic               req1_valid;
   umi_pkg::umi_cmd_t  req0_cmd;
   umi_pkg::umi_cmd_t  req1_cmd;
   umi_pkg::umi_addr_t req0_addr;
   umi_pkg::umi_addr_t req1_addr;
   umi_pkg::umi_data_t req0_data;
   umi_pkg::umi_data_t req1_data;
   logic [10:0]        req0_exp; // id, err, resp for the checker
   logic [10:0]        req1_exp;
   logic               req0_busy;
   logic               req1_busy;
   logic               resp_valid;
   umi_pkg::umi_cmd_t  resp_cmd;
   umi_pkg::umi_data_t resp_data;
   int                 done_count;
   int                 fail_count;

   test_t       tbl [$];
   logic [31:0] rng_state = 32'd92877;
   int          cycles = 0;
   int          limit = 1000; // replaced once the table is filled

   umi_mem_top dut_i (.*);
   umi_mem_checker chk_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("TIMEOUT after %0d cycles, requests did not complete", cycles);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic test_t row(input logic port, input logic [4:0] opcode,
                                 input logic [7:0] atype, input logic [2:0] size,
                                 input logic [7:0] len, input logic [15:0] addr,
                                 input logic rnd, input logic [1:0] err,
                                 input logic resp, input logic pair);
      return {port, opcode, atype, size, len, addr, rnd, err, resp, pair};
   endfunction

   // hostid is port plus one, qos carries the low test number
   function automatic umi_pkg::umi_cmd_t build_cmd(input test_t t, input int idx);
      logic [7:0] byte1;
      byte1 = (t.opcode == at) ? t.atype : t.len;
      return {5'(t.port) + 5'd1, 2'b00, 3'b000, {1'b0, t.port}, 4'(idx), byte1, t.size, t.opcode};
   endfunction

   task automatic fill_table();
      // write then read back, posted write then read
      tbl.push_back(row(1'b0, wr, 8'd0, word, 8'd0, 16'd3, 1'b1, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, rd, 8'd0, word, 8'd0, 16'd3, 1'b0, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b1, pw, 8'd0, word, 8'd0, 16'd7, 1'b1, e_ok, 1'b0, 1'b0));
      tbl.push_back(row(1'b1, rd, 8'd0, word, 8'd0, 16'd7, 1'b0, e_ok, 1'b1, 1'b0));
      // every atomic on one word, each followed by a read
      tbl.push_back(row(1'b0, wr, 8'd0, word, 8'd0, 16'd10, 1'b1, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, at, `UMI_ATOMIC_ADD, word, 8'd0, 16'd10, 1'b1, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, rd, 8'd0, word, 8'd0, 16'd10, 1'b0, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b1, at, `UMI_ATOMIC_SWAP, word, 8'd0, 16'd10, 1'b1, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b1, rd, 8'd0, word, 8'd0, 16'd10, 1'b0, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, at, `UMI_ATOMIC_AND, word, 8'd0, 16'd10, 1'b1, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, rd, 8'd0, word, 8'd0, 16'd10, 1'b0, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b1, at, `UMI_ATOMIC_OR, word, 8'd0, 16'd10, 1'b1, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b1, rd, 8'd0, word, 8'd0, 16'd10, 1'b0, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, at, `UMI_ATOMIC_XOR, word, 8'd0, 16'd10, 1'b1, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, rd, 8'd0, word, 8'd0, 16'd10, 1'b0, e_ok, 1'b1, 1'b0));
      // malformed requests aimed at word 3, then proof it is untouched
      // address 67 wraps onto word 3 in a 64 word array
      tbl.push_back(row(1'b1, 5'd7, 8'd0, word, 8'd0, 16'd3, 1'b1, e_dec, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, wr, 8'd0, 3'd1, 8'd0, 16'd3, 1'b1, e_dec, 1'b1, 1'b0));
      tbl.push_back(row(1'b1, wr, 8'd0, word, 8'd1, 16'd3, 1'b1, e_dec, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, wr, 8'd0, word, 8'd0, 16'd67, 1'b1, e_rng, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, rd, 8'd0, word, 8'd0, 16'd3, 1'b0, e_ok, 1'b1, 1'b0));
      // both ports at once on word 20, port 1 goes first as port 0 went last
      tbl.push_back(row(1'b0, wr, 8'd0, word, 8'd0, 16'd20, 1'b1, e_ok, 1'b1, 1'b1));
      tbl.push_back(row(1'b1, wr, 8'd0, word, 8'd0, 16'd20, 1'b1, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b1, rd, 8'd0, word, 8'd0, 16'd20, 1'b0, e_ok, 1'b1, 1'b0));
      tbl.push_back(row(1'b0, rd, 8'd0, word, 8'd0, 16'd20, 1'b0, e_ok, 1'b1, 1'b0));
   endtask

   task automatic drive(input test_t t, input int idx);
      umi_pkg::umi_data_t data;
      data = '0;
      if (t.rnd) begin
         rng_state = xorshift32(rng_state);
         data      = rng_state;
      end
      if (t.port) begin
         req1_valid <= 1'b1;
         req1_cmd   <= build_cmd(t, idx);
         req1_addr  <= t.addr;
         req1_data  <= data;
         req1_exp   <= {8'(idx), t.err, t.resp};
      end else begin
         req0_valid <= 1'b1;
         req0_cmd   <= build_cmd(t, idx);
         req0_addr  <= t.addr;
         req0_data  <= data;
         req0_exp   <= {8'(idx), t.err, t.resp};
      end
   endtask

   initial begin
      int idx;
      req0_valid = 1'b0;
      req0_cmd   = '0;
      req0_addr  = '0;
      req0_data  = '0;
      req0_exp   = '0;
      req1_valid = 1'b0;
      req1_cmd   = '0;
      req1_addr  = '0;
      req1_data  = '0;
      req1_exp   = '0;
      rst_n      = 1'b0;
      fill_table();
      limit = tbl.size() * 8 + 50;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      idx = 0;
      while (idx < tbl.size()) begin
         // start only once the ports are idle and every earlier test is done
         @(negedge clk);
         while (req0_busy || req1_busy || done_count != idx) @(negedge clk);
         @(posedge clk);
         drive(tbl[idx], idx);
         if (tbl[idx].pair && idx + 1 < tbl.size()) begin
            drive(tbl[idx + 1], idx + 1); // same edge, both strobes together
            idx = idx + 2;
         end else begin
            idx = idx + 1;
         end
         @(posedge clk);
         req0_valid <= 1'b0; // single-cycle strobes
         req1_valid <= 1'b0;
      end
      @(negedge clk);
      while (done_count != tbl.size()) @(negedge clk);
      $display("tests done %0d of %0d, failed checks %0d", done_count, tbl.size(), fail_count);
      if (fail_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: umi_mem.f
+incdir+src
src/umi_pkg.sv
src/umi_unpack.sv
src/umi_req_arbiter.sv
src/umi_mem_endpoint.sv
src/umi_mem_top.sv
verification/umi_mem_checker.sv
verification/umi_mem_tb.sv

// File: Makefile
# build and run the umi memory testbench with verilator
TOP = umi_mem_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f umi_mem.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
